// ==== all.f ====
csr_engine_pkg.sv
sync_fifo.sv
csr_index_configure_engine.sv
csr_index_generator.sv
csr_index_engine_top.sv
tb_csr_index_engine.sv

// ==== csr_engine_pkg.sv ====
package csr_engine_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    // Response fields and generated indices
    localparam int DATA_W = 32;

    // Packet id, carried in place of the full meta data
    localparam int ID_W = 8;

    // Response FIFO word: {id, field3, field2, field1, field0}
    localparam int RESP_W = ID_W + 4 * DATA_W;

    // Configuration FIFO word: {id, array_size, index_end, index_start}
    localparam int CFG_W = ID_W + 3 * DATA_W;

    // --------------------------------------------------
    // FIFO sizing
    // --------------------------------------------------
    localparam int FIFO_DEPTH           = 32;
    localparam int FIFO_PROG_THRESH     = 16;
    localparam int FIFO_RST_BUSY_CYCLES = 4;

    // Pointer, occupancy and reset-busy counter widths
    localparam int FIFO_AW   = $clog2(FIFO_DEPTH);
    localparam int FIFO_CW   = FIFO_AW + 1;
    localparam int RST_CNT_W = $clog2(FIFO_RST_BUSY_CYCLES + 1);

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------
    // Buffer kind of a memory response
    typedef enum logic [1:0] {
        BUF_CU_SETUP     = 2'd0,
        BUF_ENGINE_SETUP = 2'd1,
        BUF_DATA         = 2'd2,
        BUF_OTHER        = 2'd3
    } buffer_kind_e;

    // Index generator FSM
    typedef enum logic [1:0] {
        GEN_IDLE = 2'd0,
        GEN_WAIT = 2'd1,
        GEN_RUN  = 2'd2,
        GEN_DONE = 2'd3
    } gen_state_e;

endpackage

// ==== csr_index_configure_engine.sv ====
`timescale 1ns/1ps

module csr_index_configure_engine (
    input  logic                                ap_clk,
    input  logic                                areset_csr_index_generator,
    input  logic                                response_valid,
    input  csr_engine_pkg::buffer_kind_e        response_kind,
    input  logic [csr_engine_pkg::ID_W-1:0]     response_id,
    input  logic [csr_engine_pkg::DATA_W-1:0]   response_field0,
    input  logic [csr_engine_pkg::DATA_W-1:0]   response_field1,
    input  logic [csr_engine_pkg::DATA_W-1:0]   response_field2,
    input  logic [csr_engine_pkg::DATA_W-1:0]   response_field3,
    input  logic                                config_rd_en,
    output logic                                config_valid,
    output logic [csr_engine_pkg::ID_W-1:0]     config_id,
    output logic [csr_engine_pkg::DATA_W-1:0]   config_index_start,
    output logic [csr_engine_pkg::DATA_W-1:0]   config_index_end,
    output logic [csr_engine_pkg::DATA_W-1:0]   config_array_size,
    output logic                                fifo_setup
);

    logic                                   areset_fifo;

    logic                                   resp_valid_q;
    csr_engine_pkg::buffer_kind_e           resp_kind_q;
    logic [csr_engine_pkg::RESP_W-1:0]      resp_word_q;

    logic                                   resp_push;
    logic                                   resp_pop;
    logic [csr_engine_pkg::RESP_W-1:0]      resp_dout;
    logic                                   resp_dout_valid;
    logic                                   resp_empty;
    logic                                   resp_rst_busy;

    logic [csr_engine_pkg::CFG_W-1:0]       cfg_word;
    logic                                   cfg_push;
    logic                                   cfg_pop;
    logic [csr_engine_pkg::CFG_W-1:0]       cfg_dout;
    logic                                   cfg_empty;
    logic                                   cfg_prog_full;
    logic                                   cfg_rst_busy;

    // --------------------------------------------------
    // Reset copy for the FIFOs and input register
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        areset_fifo <= areset_csr_index_generator;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= response_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        resp_kind_q <= response_kind;
        resp_word_q <= {response_id, response_field3, response_field2,
                        response_field1, response_field0};
    end

    // --------------------------------------------------
    // Response FIFO
    // --------------------------------------------------
    // Only CU and engine setup packets carry a configuration
    assign resp_push = resp_valid_q &
                       ((resp_kind_q == csr_engine_pkg::BUF_CU_SETUP) |
                        (resp_kind_q == csr_engine_pkg::BUF_ENGINE_SETUP));

    // One configuration in flight at a time, and none while the queue is near full
    assign resp_pop = ~resp_empty & ~resp_dout_valid & ~cfg_push & ~cfg_prog_full;

    sync_fifo #(
        .WIDTH(csr_engine_pkg::RESP_W)
    ) u_response_fifo (
        .ap_clk   (ap_clk),
        .srst     (areset_fifo),
        .din      (resp_word_q),
        .wr_en    (resp_push),
        .rd_en    (resp_pop),
        .dout     (resp_dout),
        .valid    (resp_dout_valid),
        .empty    (resp_empty),
        .full     (),
        .prog_full(),
        .rst_busy (resp_rst_busy)
    );

    // --------------------------------------------------
    // Configuration register
    // --------------------------------------------------
    // Start from field 0, end from field 1, size from field 3
    always_ff @(posedge ap_clk) begin
        if (resp_dout_valid) begin
            cfg_word <= {resp_dout[csr_engine_pkg::RESP_W-1 -: csr_engine_pkg::ID_W],
                         resp_dout[4*csr_engine_pkg::DATA_W-1 -: csr_engine_pkg::DATA_W],
                         resp_dout[2*csr_engine_pkg::DATA_W-1 -: csr_engine_pkg::DATA_W],
                         resp_dout[csr_engine_pkg::DATA_W-1:0]};
        end
    end

    // Push one cycle after the register loads
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            cfg_push <= 1'b0;
        end else begin
            cfg_push <= resp_dout_valid;
        end
    end

    // --------------------------------------------------
    // Configuration FIFO
    // --------------------------------------------------
    assign cfg_pop = config_rd_en & ~cfg_empty;

    sync_fifo #(
        .WIDTH(csr_engine_pkg::CFG_W)
    ) u_config_fifo (
        .ap_clk   (ap_clk),
        .srst     (areset_fifo),
        .din      (cfg_word),
        .wr_en    (cfg_push),
        .rd_en    (cfg_pop),
        .dout     (cfg_dout),
        .valid    (config_valid),
        .empty    (cfg_empty),
        .full     (),
        .prog_full(cfg_prog_full),
        .rst_busy (cfg_rst_busy)
    );

    assign {config_id, config_array_size, config_index_end, config_index_start} = cfg_dout;

    // High from reset until both FIFOs leave reset-busy
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            fifo_setup <= 1'b1;
        end else begin
            fifo_setup <= resp_rst_busy | cfg_rst_busy;
        end
    end

endmodule

// ==== csr_index_engine_top.sv ====
`timescale 1ns/1ps

module csr_index_engine_top (
    input  logic                                ap_clk,
    input  logic                                areset_csr_index_generator,
    input  logic                                response_valid,
    input  csr_engine_pkg::buffer_kind_e        response_kind,
    input  logic [csr_engine_pkg::ID_W-1:0]     response_id,
    input  logic [csr_engine_pkg::DATA_W-1:0]   response_field0,
    input  logic [csr_engine_pkg::DATA_W-1:0]   response_field1,
    input  logic [csr_engine_pkg::DATA_W-1:0]   response_field2,
    input  logic [csr_engine_pkg::DATA_W-1:0]   response_field3,
    input  logic                                gen_enable,
    output logic                                fifo_setup,
    output logic                                request_valid,
    output logic [csr_engine_pkg::DATA_W-1:0]   request_index,
    output logic [csr_engine_pkg::ID_W-1:0]     request_id,
    output logic                                request_last,
    output logic                                config_done
);

    // Configuration handshake between the two stages
    logic                                   config_valid;
    logic [csr_engine_pkg::ID_W-1:0]        config_id;
    logic [csr_engine_pkg::DATA_W-1:0]      config_index_start;
    logic [csr_engine_pkg::DATA_W-1:0]      config_index_end;
    logic [csr_engine_pkg::DATA_W-1:0]      config_array_size;
    logic                                   config_rd_en;

    csr_index_configure_engine u_configure (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_valid            (response_valid),
        .response_kind             (response_kind),
        .response_id               (response_id),
        .response_field0           (response_field0),
        .response_field1           (response_field1),
        .response_field2           (response_field2),
        .response_field3           (response_field3),
        .config_rd_en              (config_rd_en),
        .config_valid              (config_valid),
        .config_id                 (config_id),
        .config_index_start        (config_index_start),
        .config_index_end          (config_index_end),
        .config_array_size         (config_array_size),
        .fifo_setup                (fifo_setup)
    );

    csr_index_generator u_generator (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .gen_enable                (gen_enable),
        .config_valid              (config_valid),
        .config_id                 (config_id),
        .config_index_start        (config_index_start),
        .config_index_end          (config_index_end),
        .config_array_size         (config_array_size),
        .config_rd_en              (config_rd_en),
        .request_valid             (request_valid),
        .request_index             (request_index),
        .request_id                (request_id),
        .request_last              (request_last),
        .config_done               (config_done)
    );

endmodule

// ==== csr_index_generator.sv ====
`timescale 1ns/1ps

module csr_index_generator (
    input  logic                                ap_clk,
    input  logic                                areset_csr_index_generator,
    input  logic                                gen_enable,
    input  logic                                config_valid,
    input  logic [csr_engine_pkg::ID_W-1:0]     config_id,
    input  logic [csr_engine_pkg::DATA_W-1:0]   config_index_start,
    input  logic [csr_engine_pkg::DATA_W-1:0]   config_index_end,
    input  logic [csr_engine_pkg::DATA_W-1:0]   config_array_size,
    output logic                                config_rd_en,
    output logic                                request_valid,
    output logic [csr_engine_pkg::DATA_W-1:0]   request_index,
    output logic [csr_engine_pkg::ID_W-1:0]     request_id,
    output logic                                request_last,
    output logic                                config_done
);

    csr_engine_pkg::gen_state_e             state;
    logic [csr_engine_pkg::DATA_W-1:0]      index;
    logic [csr_engine_pkg::DATA_W-1:0]      index_next;
    logic [csr_engine_pkg::DATA_W-1:0]      bound;
    logic [csr_engine_pkg::DATA_W-1:0]      capture_bound;
    logic [csr_engine_pkg::ID_W-1:0]        cur_id;
    logic                                   at_last;

    // The range stops at the lesser of end and array size
    assign capture_bound = (config_index_end < config_array_size) ?
                           config_index_end : config_array_size;
    assign index_next    = index + 1'b1;
    assign at_last       = (index_next == bound);

    // --------------------------------------------------
    // FSM and strobes
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            state         <= csr_engine_pkg::GEN_IDLE;
            config_rd_en  <= 1'b0;
            request_valid <= 1'b0;
            request_last  <= 1'b0;
            config_done   <= 1'b0;
        end else begin
            config_rd_en  <= 1'b0;
            request_valid <= 1'b0;
            request_last  <= 1'b0;
            config_done   <= 1'b0;
            case (state)
                csr_engine_pkg::GEN_IDLE: begin
                    // Pop request is live for one cycle, then wait for valid
                    if (config_rd_en) begin
                        state <= csr_engine_pkg::GEN_WAIT;
                    end else if (gen_enable) begin
                        config_rd_en <= 1'b1;
                    end
                end
                csr_engine_pkg::GEN_WAIT: begin
                    // No valid means the configuration FIFO was empty
                    if (!config_valid) begin
                        state <= csr_engine_pkg::GEN_IDLE;
                    end else if (config_index_start < capture_bound) begin
                        state <= csr_engine_pkg::GEN_RUN;
                    end else begin
                        state <= csr_engine_pkg::GEN_DONE;
                    end
                end
                csr_engine_pkg::GEN_RUN: begin
                    if (gen_enable) begin
                        request_valid <= 1'b1;
                        request_last  <= at_last;
                        if (at_last) begin
                            state <= csr_engine_pkg::GEN_DONE;
                        end
                    end
                end
                csr_engine_pkg::GEN_DONE: begin
                    config_done <= 1'b1;
                    state       <= csr_engine_pkg::GEN_IDLE;
                end
                default: state <= csr_engine_pkg::GEN_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Index datapath
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (state == csr_engine_pkg::GEN_WAIT && config_valid) begin
            index  <= config_index_start;
            bound  <= capture_bound;
            cur_id <= config_id;
        end else if (state == csr_engine_pkg::GEN_RUN && gen_enable) begin
            // Index holds while generation is paused
            index         <= index_next;
            request_index <= index;
            request_id    <= cur_id;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the CSR index engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_csr_index_engine \
    -f all.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// ==== sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 32
) (
    input  logic             ap_clk,
    input  logic             srst,
    input  logic [WIDTH-1:0] din,
    input  logic             wr_en,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full,
    output logic             rst_busy
);

    logic [WIDTH-1:0]                       mem [csr_engine_pkg::FIFO_DEPTH];
    logic [csr_engine_pkg::FIFO_AW-1:0]     wr_ptr;
    logic [csr_engine_pkg::FIFO_AW-1:0]     rd_ptr;
    logic [csr_engine_pkg::FIFO_CW-1:0]     count;
    logic [csr_engine_pkg::RST_CNT_W-1:0]   busy_cnt;
    logic                                   wr_ok;
    logic                                   rd_ok;

    // Status flags
    assign empty     = (count == '0);
    assign full      = (count == csr_engine_pkg::FIFO_CW'(csr_engine_pkg::FIFO_DEPTH));
    assign prog_full = (count >= csr_engine_pkg::FIFO_CW'(csr_engine_pkg::FIFO_PROG_THRESH));
    assign rst_busy  = (busy_cnt != '0);

    // Both ports are blocked during the reset-busy window
    assign wr_ok = wr_en & ~full & ~rst_busy;
    assign rd_ok = rd_en & ~empty & ~rst_busy;

    // Reset-busy countdown
    always_ff @(posedge ap_clk) begin
        if (srst) begin
            busy_cnt <= csr_engine_pkg::RST_CNT_W'(csr_engine_pkg::FIFO_RST_BUSY_CYCLES);
        end else if (rst_busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    // Pointers, occupancy and read valid
    always_ff @(posedge ap_clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= rd_ok;
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and registered read port
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

// ==== tb_csr_index_engine.sv ====
`timescale 1ns/1ps

module tb_csr_index_engine;

    // Longest test is about 480 indices at half rate plus FSM overhead
    localparam int MAX_CYCLES     = 4000;
    localparam int RANDOM_PACKETS = 20;
    // Enough for 16 configurations at one per 3 cycles after the burst
    localparam int FILL_CYCLES    = 60;

    typedef struct packed {
        logic                                 is_done;
        logic [csr_engine_pkg::DATA_W-1:0]    index;
        logic [csr_engine_pkg::ID_W-1:0]      id;
        logic                                 last;
    } expect_t;

    logic                                 ap_clk;
    logic                                 areset_csr_index_generator;
    logic                                 response_valid;
    csr_engine_pkg::buffer_kind_e         response_kind;
    logic [csr_engine_pkg::ID_W-1:0]      response_id;
    logic [csr_engine_pkg::DATA_W-1:0]    response_field0;
    logic [csr_engine_pkg::DATA_W-1:0]    response_field1;
    logic [csr_engine_pkg::DATA_W-1:0]    response_field2;
    logic [csr_engine_pkg::DATA_W-1:0]    response_field3;
    logic                                 gen_enable;
    logic                                 fifo_setup;
    logic                                 request_valid;
    logic [csr_engine_pkg::DATA_W-1:0]    request_index;
    logic [csr_engine_pkg::ID_W-1:0]      request_id;
    logic                                 request_last;
    logic                                 config_done;

    expect_t    expect_q[$];
    expect_t    head;
    string      test_name;
    int         cycle_count = 0;
    logic       done_due;

    csr_index_engine_top i_dut (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_valid            (response_valid),
        .response_kind             (response_kind),
        .response_id               (response_id),
        .response_field0           (response_field0),
        .response_field1           (response_field1),
        .response_field2           (response_field2),
        .response_field3           (response_field3),
        .gen_enable                (gen_enable),
        .fifo_setup                (fifo_setup),
        .request_valid             (request_valid),
        .request_index             (request_index),
        .request_id                (request_id),
        .request_last              (request_last),
        .config_done               (config_done)
    );

    always #10 ap_clk = ~ap_clk;

    // --------------------------------------------------
    // Failure reporting
    // --------------------------------------------------
    task automatic abort_run(input string reason);
        $display("ERROR: %s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH test=%s %s expected=0x%0h actual=0x%0h",
                 test_name, what, expected, actual);
        abort_run({"wrong ", what, " value on a request strobe"});
    endtask

    // --------------------------------------------------
    // Reference model and stimulus
    // --------------------------------------------------
    // Setup kinds give start .. min(end, size)-1, then one done
    task automatic model_packet(input csr_engine_pkg::buffer_kind_e kind,
                                input logic [csr_engine_pkg::ID_W-1:0] id,
                                input logic [31:0] start, input logic [31:0] stop,
                                input logic [31:0] size);
        logic [31:0] bound;
        logic [31:0] idx;
        expect_t     item;
        if (kind == csr_engine_pkg::BUF_CU_SETUP || kind == csr_engine_pkg::BUF_ENGINE_SETUP) begin
            bound = (stop < size) ? stop : size;
            for (idx = start; idx < bound; idx++) begin
                item = '{is_done: 1'b0, index: idx, id: id, last: (idx == bound - 32'd1)};
                expect_q.push_back(item);
            end
            item = '{is_done: 1'b1, index: '0, id: '0, last: 1'b0};
            expect_q.push_back(item);
        end
    endtask

    task automatic send_packet(input csr_engine_pkg::buffer_kind_e kind,
                               input logic [csr_engine_pkg::ID_W-1:0] id,
                               input logic [31:0] f0, input logic [31:0] f1,
                               input logic [31:0] f2, input logic [31:0] f3);
        response_valid  = 1'b1;
        response_kind   = kind;
        response_id     = id;
        response_field0 = f0;
        response_field1 = f1;
        response_field2 = f2;
        response_field3 = f3;
        model_packet(kind, id, f0, f1, f3);
        @(negedge ap_clk);
        response_valid = 1'b0;
    endtask

    task automatic wait_drained(input bit toggle_enable);
        while (expect_q.size() != 0) begin
            if (toggle_enable) begin
                gen_enable = 1'($urandom_range(0, 1));
            end
            @(negedge ap_clk);
        end
        gen_enable = 1'b1;
        // Quiet period so stray strobes still hit the checker
        repeat (20) @(negedge ap_clk);
    endtask

    // --------------------------------------------------
    // Output checker, sampled mid-cycle
    // --------------------------------------------------
    always @(negedge ap_clk) begin
        if (areset_csr_index_generator || fifo_setup) begin
            assert (!request_valid && !config_done)
            else abort_run("request or done strobe during reset or FIFO setup");
            done_due = 1'b0;
        end else begin
            if (done_due) begin
                assert (config_done)
                else abort_run("config_done did not follow the last request");
            end
            if (request_valid) begin
                assert (expect_q.size() != 0 && !expect_q[0].is_done)
                else abort_run("request strobe that the model does not expect");
                head = expect_q.pop_front();
                assert (request_index == head.index)
                else report_mismatch("index", head.index, request_index);
                assert (request_id == head.id)
                else report_mismatch("id", 32'(head.id), 32'(request_id));
                assert (request_last == head.last)
                else report_mismatch("last", 32'(head.last), 32'(request_last));
            end
            if (config_done) begin
                assert (expect_q.size() != 0 && expect_q[0].is_done)
                else abort_run("config_done strobe that the model does not expect");
                void'(expect_q.pop_front());
            end
            done_due = request_valid && request_last;
        end
    end

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run("timeout, the run did not finish within the cycle limit");
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        logic [31:0]                          start_v;
        logic [31:0]                          stop_v;
        logic [31:0]                          size_v;
        csr_engine_pkg::buffer_kind_e         kind_v;
        ap_clk                     = 1'b0;
        areset_csr_index_generator = 1'b1;
        response_valid             = 1'b0;
        response_kind              = csr_engine_pkg::BUF_DATA;
        response_id                = '0;
        response_field0            = '0;
        response_field1            = '0;
        response_field2            = '0;
        response_field3            = '0;
        gen_enable                 = 1'b0;
        test_name                  = "reset";
        void'($urandom(32'h5527_aadf));

        repeat (3) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_csr_index_generator = 1'b0;
        @(negedge ap_clk);
        assert (fifo_setup) else abort_run("fifo_setup is low right after reset");
        while (fifo_setup) begin
            @(negedge ap_clk);
        end

        test_name  = "single_cu_setup";
        gen_enable = 1'b1;
        send_packet(csr_engine_pkg::BUF_CU_SETUP, 8'h21, 32'd3, 32'd9, 32'hdead, 32'd20);
        wait_drained(1'b0);

        // Marker packet after the data kinds catches any stray output
        test_name = "filtered_kinds";
        send_packet(csr_engine_pkg::BUF_DATA, 8'h31, 32'd0, 32'd40, 32'd0, 32'd40);
        send_packet(csr_engine_pkg::BUF_OTHER, 8'h32, 32'd1, 32'd30, 32'd0, 32'd30);
        send_packet(csr_engine_pkg::BUF_ENGINE_SETUP, 8'h33, 32'd0, 32'd2, 32'd0, 32'd10);
        wait_drained(1'b0);

        test_name = "bound_rule";
        send_packet(csr_engine_pkg::BUF_CU_SETUP, 8'h41, 32'd5, 32'd50, 32'd0, 32'd12);
        send_packet(csr_engine_pkg::BUF_ENGINE_SETUP, 8'h42, 32'd10, 32'd10, 32'd0, 32'd30);
        send_packet(csr_engine_pkg::BUF_CU_SETUP, 8'h43, 32'd15, 32'd40, 32'd0, 32'd15);
        send_packet(csr_engine_pkg::BUF_ENGINE_SETUP, 8'h44, 32'd7, 32'd9, 32'd0, 32'd8);
        wait_drained(1'b0);

        // Back to back burst with the generator held off
        // Configuration FIFO reaches prog_full and the response pops stall
        test_name  = "random_burst";
        gen_enable = 1'b0;
        for (int i = 0; i < RANDOM_PACKETS; i++) begin
            start_v    = $urandom_range(0, 15);
            stop_v     = start_v + $urandom_range(0, 24);
            size_v     = $urandom_range(0, 40);
            kind_v     = ($urandom_range(0, 1) == 0) ? csr_engine_pkg::BUF_CU_SETUP :
                                                       csr_engine_pkg::BUF_ENGINE_SETUP;
            send_packet(kind_v, 8'(8'h80 + i), start_v, stop_v, $urandom(), size_v);
        end
        repeat (FILL_CYCLES) @(negedge ap_clk);
        wait_drained(1'b1);

        $display("=== PASS ===");
        $finish;
    end

endmodule
